// ==== hw/soc_pkg.sv ====
// ----------------------------------------------------------------------
// SoC bus package
// Bus request and response structs, address map and memory sizes
// ----------------------------------------------------------------------
`default_nettype none

package soc_pkg;

	// Address map, base inclusive and limit exclusive
	localparam logic [31:0] RAM_BASE   = 32'h0001_0000;
	localparam logic [31:0] RAM_LIMIT  = 32'h0002_0000;
	localparam logic [31:0] SRAM_BASE  = 32'h1000_0000;
	localparam logic [31:0] SRAM_LIMIT = 32'h2000_0000;
	localparam logic [31:0] LED_BASE   = 32'h5000_0000;
	localparam logic [31:0] LED_LIMIT  = 32'h5000_0010;

	// Memory and peripheral sizes
	localparam int BRAM_WORDS = 256;
	localparam int SRAM_AW    = 18;
	localparam int LED_W      = 10;

	// 32-bit system bus
	typedef struct packed {
		logic        request;
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
	} bus_rsp_t;

	// 16-bit side of the SRAM adapter, half-word addressed
	typedef struct packed {
		logic               request;
		logic               rw;
		logic [SRAM_AW-1:0] address;
		logic [15:0]        wdata;
	} sram_req_t;

	typedef struct packed {
		logic [15:0] rdata;
		logic        ready;
	} sram_rsp_t;

endpackage

`default_nettype wire

// ==== hw/soc_bus_decoder.sv ====
// ----------------------------------------------------------------------
// Bus address decoder
// Steers the master request to one target with its base removed and
// returns that target's response; unmapped accesses complete with zero
// ----------------------------------------------------------------------
`default_nettype none

module soc_bus_decoder (
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  soc_pkg::bus_req_t i_bus,
	output soc_pkg::bus_rsp_t o_bus,
	output soc_pkg::bus_req_t o_ram_req,
	input  soc_pkg::bus_rsp_t i_ram_rsp,
	output soc_pkg::bus_req_t o_sram_req,
	input  soc_pkg::bus_rsp_t i_sram_rsp,
	output soc_pkg::bus_req_t o_led_req,
	input  soc_pkg::bus_rsp_t i_led_rsp
);
	import soc_pkg::*;

	logic sel_ram;
	logic sel_sram;
	logic sel_led;
	logic sel_none;
	logic unmapped_ready;

	assign sel_ram  = (i_bus.address >= RAM_BASE) && (i_bus.address < RAM_LIMIT);
	assign sel_sram = (i_bus.address >= SRAM_BASE) && (i_bus.address < SRAM_LIMIT);
	assign sel_led  = (i_bus.address >= LED_BASE) && (i_bus.address < LED_LIMIT);
	assign sel_none = !(sel_ram || sel_sram || sel_led);

	// Request goes only to the selected target, offset from its base
	always_comb begin
		o_ram_req          = i_bus;
		o_ram_req.request  = i_bus.request && sel_ram;
		o_ram_req.address  = i_bus.address - RAM_BASE;

		o_sram_req         = i_bus;
		o_sram_req.request = i_bus.request && sel_sram;
		o_sram_req.address = i_bus.address - SRAM_BASE;

		o_led_req          = i_bus;
		o_led_req.request  = i_bus.request && sel_led;
		o_led_req.address  = i_bus.address - LED_BASE;
	end

	// Answer unmapped accesses so the master never stalls
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= i_bus.request && sel_none && !unmapped_ready;
		end
	end

	always_comb begin
		if (sel_ram) begin
			o_bus = i_ram_rsp;
		end else if (sel_sram) begin
			o_bus = i_sram_rsp;
		end else if (sel_led) begin
			o_bus = i_led_rsp;
		end else begin
			o_bus = '{rdata: 32'h0, ready: unmapped_ready};
		end
	end

endmodule

`default_nettype wire

// ==== hw/soc_bram.sv ====
// ----------------------------------------------------------------------
// Block RAM target
// Single-port 32-bit memory, one access per request, ready next cycle
// ----------------------------------------------------------------------
`default_nettype none

module soc_bram (
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);
	import soc_pkg::*;

	logic [31:0]                   mem [BRAM_WORDS];
	logic [$clog2(BRAM_WORDS)-1:0] word_idx;
	logic [31:0]                   rdata_q;
	logic                          ready_q;
	logic                          done_q;
	logic                          start;

	// Byte address to word index, upper offset bits alias
	assign word_idx = i_req.address[$clog2(BRAM_WORDS)+1:2];
	assign start    = i_req.request && !done_q;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			ready_q <= start;
			// Held until the master drops its request
			if (!i_req.request) begin
				done_q <= 1'b0;
			end else if (start) begin
				done_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (start && i_req.rw) begin
			mem[word_idx] <= i_req.wdata;
		end
		if (start) begin
			rdata_q <= i_req.rw ? 32'h0 : mem[word_idx];
		end
	end

	assign o_rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

// ==== hw/soc_mem_16_to_32.sv ====
// ----------------------------------------------------------------------
// 32-to-16 bit memory adapter
// Splits each 32-bit access into a low and a high half-word access
// on the 16-bit SRAM side, then completes the 32-bit access
// ----------------------------------------------------------------------
`default_nettype none

module soc_mem_16_to_32 (
	input  logic               i_clock,
	input  logic               i_rst_n,
	input  soc_pkg::bus_req_t  i_req,
	output soc_pkg::bus_rsp_t  o_rsp,
	output soc_pkg::sram_req_t o_ram_req,
	input  soc_pkg::sram_rsp_t i_ram_rsp
);
	import soc_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOW,
		S_GAP,
		S_HIGH,
		S_DONE
	} state_t;

	state_t             state;
	logic [SRAM_AW-2:0] word_idx;
	logic               high_half;
	logic [15:0]        lo_q;
	logic [15:0]        hi_q;

	// 32-bit word index from offset bits 18:2
	assign word_idx  = i_req.address[SRAM_AW:2];
	assign high_half = (state == S_HIGH);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (i_req.request) state <= S_LOW;
				S_LOW: if (i_ram_rsp.ready) state <= S_GAP;
				// One idle cycle so the SRAM side sees request drop
				S_GAP: state <= S_HIGH;
				S_HIGH: if (i_ram_rsp.ready) state <= S_DONE;
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Half-word capture, writes come back as zero from the SRAM side
	always_ff @(posedge i_clock) begin
		if (state == S_LOW && i_ram_rsp.ready) begin
			lo_q <= i_ram_rsp.rdata;
		end
		if (state == S_HIGH && i_ram_rsp.ready) begin
			hi_q <= i_ram_rsp.rdata;
		end
	end

	always_comb begin
		o_ram_req.request = (state == S_LOW) || (state == S_HIGH);
		o_ram_req.rw      = i_req.rw;
		o_ram_req.address = {word_idx, high_half};
		o_ram_req.wdata   = high_half ? i_req.wdata[31:16] : i_req.wdata[15:0];
	end

	assign o_rsp = '{rdata: {hi_q, lo_q}, ready: (state == S_DONE)};

endmodule

`default_nettype wire

// ==== hw/soc_sram_interface.sv ====
// ----------------------------------------------------------------------
// Asynchronous SRAM controller
// Drives the 16-bit SRAM pins with a fixed two-cycle access
// ----------------------------------------------------------------------
`default_nettype none

module soc_sram_interface (
	input  logic                         i_clock,
	input  logic                         i_rst_n,
	input  soc_pkg::sram_req_t           i_req,
	output soc_pkg::sram_rsp_t           o_rsp,
	output logic [soc_pkg::SRAM_AW-1:0]  o_sram_a,
	output logic [15:0]                  o_sram_d,
	input  logic [15:0]                  i_sram_d,
	output logic                         o_sram_ce_n,
	output logic                         o_sram_oe_n,
	output logic                         o_sram_we_n,
	output logic                         o_sram_lb_n,
	output logic                         o_sram_ub_n
);

	typedef enum logic {
		S_IDLE,
		S_ACCESS
	} state_t;

	state_t      state;
	logic        ready_q;
	logic [15:0] rdata_q;
	logic        start;

	// Ready still high means the finished request has not dropped yet
	assign start = (state == S_IDLE) && i_req.request && !ready_q;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= S_IDLE;
			ready_q     <= 1'b0;
			o_sram_ce_n <= 1'b1;
			o_sram_oe_n <= 1'b1;
			o_sram_we_n <= 1'b1;
			o_sram_lb_n <= 1'b1;
			o_sram_ub_n <= 1'b1;
		end else begin
			ready_q <= 1'b0;
			if (start) begin
				state       <= S_ACCESS;
				o_sram_ce_n <= 1'b0;
				o_sram_lb_n <= 1'b0;
				o_sram_ub_n <= 1'b0;
				o_sram_oe_n <= i_req.rw;
				o_sram_we_n <= !i_req.rw;
			end else if (state == S_ACCESS) begin
				// Rising write enable commits the data
				state       <= S_IDLE;
				ready_q     <= 1'b1;
				o_sram_we_n <= 1'b1;
			end else begin
				o_sram_ce_n <= 1'b1;
				o_sram_oe_n <= 1'b1;
				o_sram_lb_n <= 1'b1;
				o_sram_ub_n <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (start) begin
			o_sram_a <= i_req.address;
			o_sram_d <= i_req.wdata;
		end
		if (state == S_ACCESS) begin
			rdata_q <= i_req.rw ? 16'h0 : i_sram_d;
		end
	end

	assign o_rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

// ==== hw/soc_led.sv ====
// ----------------------------------------------------------------------
// Red LED register, written over the bus
// ----------------------------------------------------------------------
`default_nettype none

module soc_led (
	input  logic                      i_clock,
	input  logic                      i_rst_n,
	input  soc_pkg::bus_req_t         i_req,
	output soc_pkg::bus_rsp_t         o_rsp,
	output logic [soc_pkg::LED_W-1:0] o_ledr
);
	import soc_pkg::*;

	logic ready_q;
	logic done_q;
	logic start;

	assign start = i_req.request && !done_q;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
			done_q  <= 1'b0;
			o_ledr  <= '0;
		end else begin
			ready_q <= start;
			done_q  <= i_req.request && (done_q || start);
			if (start && i_req.rw) begin
				o_ledr <= i_req.wdata[LED_W-1:0];
			end
		end
	end

	// Write-only register, reads return zero
	assign o_rsp = '{rdata: 32'h0, ready: ready_q};

endmodule

`default_nettype wire

// ==== hw/soc_top.sv ====
// ----------------------------------------------------------------------
// SoC bus fabric top level
// External bus master port decoded onto block RAM, SRAM and LEDs
// ----------------------------------------------------------------------
`default_nettype none

module soc_top (
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  soc_pkg::bus_req_t           i_bus,
	output soc_pkg::bus_rsp_t           o_bus,
	output logic [soc_pkg::SRAM_AW-1:0] o_sram_a,
	output logic [15:0]                 o_sram_d,
	input  logic [15:0]                 i_sram_d,
	output logic                        o_sram_ce_n,
	output logic                        o_sram_oe_n,
	output logic                        o_sram_we_n,
	output logic                        o_sram_lb_n,
	output logic                        o_sram_ub_n,
	output logic [soc_pkg::LED_W-1:0]   o_ledr
);
	import soc_pkg::*;

	bus_req_t  ram_req;
	bus_rsp_t  ram_rsp;
	bus_req_t  sram32_req;
	bus_rsp_t  sram32_rsp;
	bus_req_t  led_req;
	bus_rsp_t  led_rsp;
	sram_req_t sram16_req;
	sram_rsp_t sram16_rsp;

	soc_bus_decoder u_decoder (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_bus      (i_bus),
		.o_bus      (o_bus),
		.o_ram_req  (ram_req),
		.i_ram_rsp  (ram_rsp),
		.o_sram_req (sram32_req),
		.i_sram_rsp (sram32_rsp),
		.o_led_req  (led_req),
		.i_led_rsp  (led_rsp)
	);

	soc_bram u_bram (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	// 32-bit accesses to the 16-bit external SRAM
	soc_mem_16_to_32 u_sram32 (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_req     (sram32_req),
		.o_rsp     (sram32_rsp),
		.o_ram_req (sram16_req),
		.i_ram_rsp (sram16_rsp)
	);

	soc_sram_interface u_sram (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_req       (sram16_req),
		.o_rsp       (sram16_rsp),
		.o_sram_a    (o_sram_a),
		.o_sram_d    (o_sram_d),
		.i_sram_d    (i_sram_d),
		.o_sram_ce_n (o_sram_ce_n),
		.o_sram_oe_n (o_sram_oe_n),
		.o_sram_we_n (o_sram_we_n),
		.o_sram_lb_n (o_sram_lb_n),
		.o_sram_ub_n (o_sram_ub_n)
	);

	soc_led u_led (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_req   (led_req),
		.o_rsp   (led_rsp),
		.o_ledr  (o_ledr)
	);

endmodule

`default_nettype wire

// ==== tests/soc_assertions.sv ====
// ----------------------------------------------------------------------
// Bus protocol and SRAM strobe checks, bound into the SoC top level
// ----------------------------------------------------------------------
`default_nettype none

module soc_assertions (
	input logic                        i_clock,
	input logic                        i_rst_n,
	input soc_pkg::bus_rsp_t           i_bus_rsp,
	input soc_pkg::sram_req_t          i_sram_req,
	input soc_pkg::bus_req_t           i_led_req,
	input soc_pkg::bus_rsp_t           i_led_rsp,
	input logic                        i_ce_n,
	input logic                        i_oe_n,
	input logic                        i_we_n,
	input logic                        i_lb_n,
	input logic                        i_ub_n,
	input logic [soc_pkg::LED_W-1:0]   i_ledr
);
	timeunit 1ns;
	timeprecision 1ps;

	// Ready is a single-cycle pulse
	a_ready_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_bus_rsp.ready |=> !i_bus_rsp.ready)
		else $error("master ready stayed high for two cycles");

	a_oe_we: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(!i_we_n && !i_oe_n))
		else $error("SRAM write and output enable low together");

	// No 16-bit request means the SRAM pins are idle
	a_idle_strobes: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!i_sram_req.request |-> (i_ce_n && i_oe_n && i_we_n && i_lb_n && i_ub_n))
		else $error("SRAM strobe active outside an access");

	a_led_update: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_ledr != $past(i_ledr)) |-> (i_led_rsp.ready && $past(i_led_req.rw)))
		else $error("LED outputs changed without a completed LED write");

endmodule

bind soc_top soc_assertions u_assertions (
	.i_clock    (i_clock),
	.i_rst_n    (i_rst_n),
	.i_bus_rsp  (o_bus),
	.i_sram_req (sram16_req),
	.i_led_req  (led_req),
	.i_led_rsp  (led_rsp),
	.i_ce_n     (o_sram_ce_n),
	.i_oe_n     (o_sram_oe_n),
	.i_we_n     (o_sram_we_n),
	.i_lb_n     (o_sram_lb_n),
	.i_ub_n     (o_sram_ub_n),
	.i_ledr     (o_ledr)
);

`default_nettype wire

// ==== tests/soc_tb.sv ====
// ----------------------------------------------------------------------
// SoC bus fabric testbench
// Plays the bus master, models the SRAM chip and checks every read
// against a reference model of the address map
// ----------------------------------------------------------------------
`default_nettype none

module soc_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	// Limit well above the 736 accesses of at most 10 cycles each
	localparam int MAX_ACCESSES   = 800;
	localparam int TIMEOUT_CYCLES = MAX_ACCESSES * 25;

	logic               clock;
	logic               rst_n;
	bus_req_t           bus_req;
	bus_rsp_t           bus_rsp;
	logic [SRAM_AW-1:0] sram_a;
	logic [15:0]        sram_dq_out;
	logic [15:0]        sram_dq_in;
	logic               sram_ce_n;
	logic               sram_oe_n;
	logic               sram_we_n;
	logic               sram_lb_n;
	logic               sram_ub_n;
	logic [LED_W-1:0]   ledr;

	logic [15:0]      sram_chip [1<<SRAM_AW];
	logic [31:0]      ram_model [BRAM_WORDS];
	logic [31:0]      sram_ref [int];
	logic [LED_W-1:0] led_ref;
	logic [31:0]      exp_rdata;
	logic [31:0]      lfsr;
	string            test_name;
	int               errors;
	int               checks;
	int               cycle_count;

	soc_top uut (
		.i_clock     (clock),
		.i_rst_n     (rst_n),
		.i_bus       (bus_req),
		.o_bus       (bus_rsp),
		.o_sram_a    (sram_a),
		.o_sram_d    (sram_dq_out),
		.i_sram_d    (sram_dq_in),
		.o_sram_ce_n (sram_ce_n),
		.o_sram_oe_n (sram_oe_n),
		.o_sram_we_n (sram_we_n),
		.o_sram_lb_n (sram_lb_n),
		.o_sram_ub_n (sram_ub_n),
		.o_ledr      (ledr)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Power-up contents of the SRAM chip from the whole half-word address
	function automatic logic [15:0] sram_fill(input logic [SRAM_AW-1:0] a);
		return a[15:0] ^ {a[17:16], a[17:16], a[17:16], 10'h2c5};
	endfunction

	// Asynchronous SRAM chip that writes on the rising write enable
	initial begin
		for (int i = 0; i < (1 << SRAM_AW); i++) begin
			sram_chip[i] = sram_fill(SRAM_AW'(i));
		end
	end

	// Byte lanes that are not enabled float
	assign sram_dq_in = (!sram_ce_n && !sram_oe_n) ?
		{(sram_ub_n ? 8'hzz : sram_chip[sram_a][15:8]),
		(sram_lb_n ? 8'hzz : sram_chip[sram_a][7:0])} : 16'h0;

	always @(posedge sram_we_n) begin
		if (sram_ce_n === 1'b0) begin
			if (sram_lb_n === 1'b0) begin
				sram_chip[sram_a][7:0] <= sram_dq_out[7:0];
			end
			if (sram_ub_n === 1'b0) begin
				sram_chip[sram_a][15:8] <= sram_dq_out[15:8];
			end
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// Expected read data from the address map rules
	function automatic logic [31:0] expected_rdata(input logic rw, input logic [31:0] addr);
		logic [31:0] off;
		logic [16:0] w;
		if (rw) return 32'h0;
		if (addr >= RAM_BASE && addr < RAM_LIMIT) begin
			off = addr - RAM_BASE;
			return ram_model[off[9:2]];
		end
		if (addr >= SRAM_BASE && addr < SRAM_LIMIT) begin
			off = addr - SRAM_BASE;
			w   = off[18:2];
			if (sram_ref.exists(int'(w))) return sram_ref[int'(w)];
			return {sram_fill({w, 1'b1}), sram_fill({w, 1'b0})};
		end
		// LED reads and unmapped space
		return 32'h0;
	endfunction

	function automatic void record_write(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] off;
		if (addr >= RAM_BASE && addr < RAM_LIMIT) begin
			off = addr - RAM_BASE;
			ram_model[off[9:2]] = wdata;
		end else if (addr >= SRAM_BASE && addr < SRAM_LIMIT) begin
			off = addr - SRAM_BASE;
			sram_ref[int'(off[18:2])] = wdata;
		end else if (addr >= LED_BASE && addr < LED_LIMIT) begin
			led_ref = wdata[LED_W-1:0];
		end
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
		end
	endtask

	// One access, called on a falling edge; latency counts cycles to ready
	task automatic bus_access(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, output int latency);
		exp_rdata = expected_rdata(rw, addr);
		if (rw) record_write(addr, wdata);
		bus_req = '{request: 1'b1, rw: rw, address: addr, wdata: wdata};
		latency = 0;
		do begin
			@(negedge clock);
			latency++;
		end while (!bus_rsp.ready);
		bus_req.request = 1'b0;
		@(negedge clock);
	endtask

	// Every completed access is compared against the reference
	always @(negedge clock) begin
		if (rst_n && bus_rsp.ready) begin
			check(test_name, exp_rdata, bus_rsp.rdata);
			check({test_name, " ledr"}, 32'(led_ref), 32'(ledr));
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	initial begin : stimulus
		int          lat;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] addrs [$];
		logic [16:0] w;
		logic [31:0] holes [4];
		holes       = '{32'h3000_0000, 32'h5000_0040, 32'h0000_0000, 32'hffff_fffc};
		lfsr        = 32'h9824_3254;
		errors      = 0;
		checks      = 0;
		cycle_count = 0;
		led_ref     = '0;
		exp_rdata   = '0;
		rst_n       = 1'b0;
		bus_req     = '0;
		test_name   = "reset";
		repeat (8) @(negedge clock);
		check("reset ready", 32'h0, 32'(bus_rsp.ready));
		check("reset strobes", 32'h1f,
			32'({sram_ce_n, sram_oe_n, sram_we_n, sram_lb_n, sram_ub_n}));
		check("reset ledr", 32'h0, 32'(ledr));
		rst_n = 1'b1;
		@(negedge clock);

		// Known contents first so any word can be read later
		test_name = "bram fill";
		for (int i = 0; i < BRAM_WORDS; i++) begin
			bus_access(1'b1, RAM_BASE + 32'(i * 4),
				(32'(i) * 32'h0101_0101) ^ 32'hc3a5_0000, lat);
		end
		test_name = "bram write";
		repeat (64) begin
			addr = RAM_BASE + (random_bits(14) << 2);
			bus_access(1'b1, addr, random_bits(32), lat);
			check("bram write latency", 32'd1, 32'(lat));
			addrs.push_back(addr);
		end
		// Read back through an alias above word 255
		test_name = "bram read";
		foreach (addrs[i]) begin
			data = random_bits(6);
			addr = {addrs[i][31:16], data[5:0], addrs[i][9:0]};
			bus_access(1'b0, addr, 32'h0, lat);
			check("bram read latency", 32'd1, 32'(lat));
		end

		test_name = "sram write";
		addrs.delete();
		repeat (64) begin
			addr = SRAM_BASE + (random_bits(26) << 2);
			data = random_bits(32);
			bus_access(1'b1, addr, data, lat);
			w = addr[18:2];
			check("sram low half", 32'(data[15:0]), 32'(sram_chip[{w, 1'b0}]));
			check("sram high half", 32'(data[31:16]), 32'(sram_chip[{w, 1'b1}]));
			addrs.push_back(addr);
		end
		test_name = "sram read";
		foreach (addrs[i]) begin
			bus_access(1'b0, addrs[i], 32'h0, lat);
		end

		test_name = "led";
		repeat (8) begin
			data = random_bits(32);
			bus_access(1'b1, LED_BASE + (random_bits(2) << 2), data, lat);
			check("led write latency", 32'd1, 32'(lat));
			check("led value", 32'(data[LED_W-1:0]), 32'(ledr));
			bus_access(1'b0, LED_BASE, 32'h0, lat);
		end

		test_name = "unmapped";
		foreach (holes[i]) begin
			bus_access(1'b1, holes[i], 32'hdead_beef, lat);
			check("unmapped write latency", 32'd1, 32'(lat));
			bus_access(1'b0, holes[i], 32'h0, lat);
			check("unmapped read latency", 32'd1, 32'(lat));
		end

		test_name = "mixed";
		repeat (200) begin
			data = random_bits(2);
			case (data[1:0])
				2'd0: addr = RAM_BASE + (random_bits(14) << 2);
				2'd1: addr = SRAM_BASE + (random_bits(16) << 2);
				2'd2: addr = LED_BASE + (random_bits(2) << 2);
				default: addr = 32'h2000_0000 + (random_bits(28) << 2);
			endcase
			data = random_bits(1);
			bus_access(data[0], addr, random_bits(32), lat);
		end

		$display("Finished: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/soc_pkg.sv
hw/soc_bus_decoder.sv
hw/soc_bram.sv
hw/soc_mem_16_to_32.sv
hw/soc_sram_interface.sv
hw/soc_led.sv
hw/soc_top.sv
tests/soc_assertions.sv
tests/soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_bus_fabric

sources:
  - hw/soc_pkg.sv
  - hw/soc_bus_decoder.sv
  - hw/soc_bram.sv
  - hw/soc_mem_16_to_32.sv
  - hw/soc_sram_interface.sv
  - hw/soc_led.sv
  - hw/soc_top.sv
  - target: simulation
    files:
      - tests/soc_assertions.sv
      - tests/soc_tb.sv
